// File: core_backend.f
design/isa_pkg.sv
design/pipe_pkg.sv
design/reg_file.sv
design/alu_lane.sv
design/commit_stage.sv
design/issue_unit.sv
design/core_backend.sv
test/core_backend_assert.sv
test/core_backend_tb.sv

// File: design/alu_lane.sv
`timescale 1ns/10ps

module alu_lane (
    input  logic              clk,
    input  logic              reset_i,
    input  pipe_pkg::issue_t  issue_i,
    output isa_pkg::word_t    fwd_value_o,
    output pipe_pkg::result_t result_o
);

    isa_pkg::word_t value;
    logic           lt_signed;
    logic           lt_unsigned;

    assign lt_signed   = $signed(issue_i.a) < $signed(issue_i.b);
    assign lt_unsigned = issue_i.a < issue_i.b;

    always_comb begin
        case (issue_i.alu_op)
            isa_pkg::alu_add:  value = issue_i.a + issue_i.b;
            isa_pkg::alu_sub:  value = issue_i.a - issue_i.b;
            isa_pkg::alu_slt:  value = {{(isa_pkg::xlen-1){1'b0}}, lt_signed};
            isa_pkg::alu_sltu: value = {{(isa_pkg::xlen-1){1'b0}}, lt_unsigned};
            isa_pkg::alu_and:  value = issue_i.a & issue_i.b;
            isa_pkg::alu_or:   value = issue_i.a | issue_i.b;
            isa_pkg::alu_xor:  value = issue_i.a ^ issue_i.b;
            default:           value = ~(issue_i.a | issue_i.b);
        endcase
    end

    // Same-cycle value for the issue stage bypass
    assign fwd_value_o = value;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            result_o <= '0;
        end else begin
            result_o.valid <= issue_i.valid;
            result_o.pc    <= issue_i.pc;
            result_o.rd    <= issue_i.rd;
            result_o.we    <= issue_i.we;
            result_o.value <= value;
        end
    end

endmodule

// File: design/commit_stage.sv
`timescale 1ns/10ps

module commit_stage (
    input  logic                                     clk,
    input  logic                                     reset_i,
    input  pipe_pkg::result_t [pipe_pkg::lanes-1:0]  result_i,
    output logic [pipe_pkg::lanes-1:0]               rf_we_o,
    output isa_pkg::reg_addr_t [pipe_pkg::lanes-1:0] rf_waddr_o,
    output isa_pkg::word_t [pipe_pkg::lanes-1:0]     rf_wdata_o,
    output pipe_pkg::result_t [pipe_pkg::lanes-1:0]  fwd_o,
    output isa_pkg::word_t                           debug0_wb_pc_o,
    output logic [3:0]                               debug0_wb_rf_wen_o,
    output isa_pkg::reg_addr_t                       debug0_wb_rf_wnum_o,
    output isa_pkg::word_t                           debug0_wb_rf_wdata_o,
    output isa_pkg::word_t                           debug1_wb_pc_o,
    output logic [3:0]                               debug1_wb_rf_wen_o,
    output isa_pkg::reg_addr_t                       debug1_wb_rf_wnum_o,
    output isa_pkg::word_t                           debug1_wb_rf_wdata_o
);

    always_comb begin
        for (int l = 0; l < pipe_pkg::lanes; l++) begin
            rf_we_o[l]    = result_i[l].valid && result_i[l].we && result_i[l].rd != '0;
            rf_waddr_o[l] = result_i[l].rd;
            rf_wdata_o[l] = result_i[l].value;
        end
    end

    // Results not yet visible in the register file
    assign fwd_o = result_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            debug0_wb_rf_wen_o <= 4'h0;
            debug1_wb_rf_wen_o <= 4'h0;
        end else begin
            debug0_wb_rf_wen_o <= {3'b000, rf_we_o[0]};
            debug1_wb_rf_wen_o <= {3'b000, rf_we_o[1]};
        end
    end

    always_ff @(posedge clk) begin
        debug0_wb_pc_o       <= result_i[0].pc;
        debug0_wb_rf_wnum_o  <= rf_waddr_o[0];
        debug0_wb_rf_wdata_o <= rf_wdata_o[0];
        debug1_wb_pc_o       <= result_i[1].pc;
        debug1_wb_rf_wnum_o  <= rf_waddr_o[1];
        debug1_wb_rf_wdata_o <= rf_wdata_o[1];
    end

endmodule

// File: design/core_backend.sv
`timescale 1ns/10ps

module core_backend (
    input  logic                               clk,
    input  logic                               reset_i,
    input  logic [pipe_pkg::lanes-1:0]         instr_valid_i,
    input  isa_pkg::instr_u [pipe_pkg::lanes-1:0] instr_i,
    input  isa_pkg::word_t                     pc_i,
    output logic                               stall_o,
    output isa_pkg::word_t                     debug0_wb_pc_o,
    output logic [3:0]                         debug0_wb_rf_wen_o,
    output isa_pkg::reg_addr_t                 debug0_wb_rf_wnum_o,
    output isa_pkg::word_t                     debug0_wb_rf_wdata_o,
    output isa_pkg::word_t                     debug1_wb_pc_o,
    output logic [3:0]                         debug1_wb_rf_wen_o,
    output isa_pkg::reg_addr_t                 debug1_wb_rf_wnum_o,
    output isa_pkg::word_t                     debug1_wb_rf_wdata_o
);

    isa_pkg::reg_addr_t [pipe_pkg::rd_ports-1:0] rf_raddr;
    isa_pkg::word_t [pipe_pkg::rd_ports-1:0]     rf_rdata;
    isa_pkg::word_t [pipe_pkg::lanes-1:0]        lane_fwd_value;
    pipe_pkg::issue_t [pipe_pkg::lanes-1:0]      lane_issue;
    pipe_pkg::result_t [pipe_pkg::lanes-1:0]     lane_result;
    pipe_pkg::result_t [pipe_pkg::lanes-1:0]     commit_fwd;
    logic [pipe_pkg::lanes-1:0]                  rf_we;
    isa_pkg::reg_addr_t [pipe_pkg::lanes-1:0]    rf_waddr;
    isa_pkg::word_t [pipe_pkg::lanes-1:0]        rf_wdata;

    issue_unit u_issue_unit (
        .clk              (clk),
        .reset_i          (reset_i),
        .instr_valid_i    (instr_valid_i),
        .instr_i          (instr_i),
        .pc_i             (pc_i),
        .stall_o          (stall_o),
        .rf_raddr_o       (rf_raddr),
        .rf_rdata_i       (rf_rdata),
        .lane_fwd_value_i (lane_fwd_value),
        .lane_issue_o     (lane_issue),
        .commit_fwd_i     (commit_fwd)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .reset_i (reset_i),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata)
    );

    for (genvar l = 0; l < pipe_pkg::lanes; l++) begin : g_lane
        alu_lane u_alu_lane (
            .clk         (clk),
            .reset_i     (reset_i),
            .issue_i     (lane_issue[l]),
            .fwd_value_o (lane_fwd_value[l]),
            .result_o    (lane_result[l])
        );
    end

    commit_stage u_commit_stage (
        .clk                  (clk),
        .reset_i              (reset_i),
        .result_i             (lane_result),
        .rf_we_o              (rf_we),
        .rf_waddr_o           (rf_waddr),
        .rf_wdata_o           (rf_wdata),
        .fwd_o                (commit_fwd),
        .debug0_wb_pc_o       (debug0_wb_pc_o),
        .debug0_wb_rf_wen_o   (debug0_wb_rf_wen_o),
        .debug0_wb_rf_wnum_o  (debug0_wb_rf_wnum_o),
        .debug0_wb_rf_wdata_o (debug0_wb_rf_wdata_o),
        .debug1_wb_pc_o       (debug1_wb_pc_o),
        .debug1_wb_rf_wen_o   (debug1_wb_rf_wen_o),
        .debug1_wb_rf_wnum_o  (debug1_wb_rf_wnum_o),
        .debug1_wb_rf_wdata_o (debug1_wb_rf_wdata_o)
    );

endmodule

// File: design/isa_pkg.sv
package isa_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // Three-register format
    typedef struct packed {
        logic [16:0] opcode17;
        reg_addr_t   rk;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } r3_t;

    // Two registers and a 12-bit immediate
    typedef struct packed {
        logic [9:0]  opcode10;
        logic [11:0] imm12;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } ri12_t;

    // One register and a 20-bit immediate
    typedef struct packed {
        logic [6:0]  opcode7;
        logic [19:0] imm20;
        reg_addr_t   rd;
    } ri20_t;

    typedef union packed {
        r3_t   r3;
        ri12_t ri12;
        ri20_t ri20;
    } instr_u;

    // 3R opcodes, bits 31:15
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_slt   = 17'h00024;
    localparam logic [16:0] op_sltu  = 17'h00025;
    localparam logic [16:0] op_nor   = 17'h00028;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;

    // 2RI12 opcodes, bits 31:22
    localparam logic [9:0] op_slti   = 10'h008;
    localparam logic [9:0] op_sltui  = 10'h009;
    localparam logic [9:0] op_addi_w = 10'h00a;
    localparam logic [9:0] op_andi   = 10'h00d;
    localparam logic [9:0] op_ori    = 10'h00e;
    localparam logic [9:0] op_xori   = 10'h00f;

    // 1RI20 opcode, bits 31:25
    localparam logic [6:0] op_lu12i_w = 7'h0a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor
    } alu_op_e;

endpackage

// File: design/issue_unit.sv
`timescale 1ns/10ps

module issue_unit (
    input  logic                                        clk,
    input  logic                                        reset_i,
    input  logic [pipe_pkg::lanes-1:0]                  instr_valid_i,
    input  isa_pkg::instr_u [pipe_pkg::lanes-1:0]       instr_i,
    input  isa_pkg::word_t                              pc_i,
    output logic                                        stall_o,
    output isa_pkg::reg_addr_t [pipe_pkg::rd_ports-1:0] rf_raddr_o,
    input  isa_pkg::word_t [pipe_pkg::rd_ports-1:0]     rf_rdata_i,
    input  isa_pkg::word_t [pipe_pkg::lanes-1:0]        lane_fwd_value_i,
    output pipe_pkg::issue_t [pipe_pkg::lanes-1:0]      lane_issue_o,
    input  pipe_pkg::result_t [pipe_pkg::lanes-1:0]     commit_fwd_i
);

    typedef struct packed {
        isa_pkg::alu_op_e   alu_op;
        isa_pkg::reg_addr_t rj;
        isa_pkg::reg_addr_t rk;
        isa_pkg::reg_addr_t rd;
        logic               we;
        logic               use_imm;
        isa_pkg::word_t     imm;
    } dec_t;

    // Unused sources are forced to r0 so they never match a producer
    function automatic dec_t decode(isa_pkg::instr_u ins);
        dec_t d;
        logic known;
        d        = '0;
        known    = 1'b1;
        d.rj     = ins.r3.rj;
        d.rk     = ins.r3.rk;
        d.rd     = ins.r3.rd;
        case (ins.r3.opcode17)
            isa_pkg::op_add_w: d.alu_op = isa_pkg::alu_add;
            isa_pkg::op_sub_w: d.alu_op = isa_pkg::alu_sub;
            isa_pkg::op_slt:   d.alu_op = isa_pkg::alu_slt;
            isa_pkg::op_sltu:  d.alu_op = isa_pkg::alu_sltu;
            isa_pkg::op_and:   d.alu_op = isa_pkg::alu_and;
            isa_pkg::op_or:    d.alu_op = isa_pkg::alu_or;
            isa_pkg::op_xor:   d.alu_op = isa_pkg::alu_xor;
            isa_pkg::op_nor:   d.alu_op = isa_pkg::alu_nor;
            default: begin
                d.rk      = '0;
                d.use_imm = 1'b1;
                d.imm     = {{20{ins.ri12.imm12[11]}}, ins.ri12.imm12};
                case (ins.ri12.opcode10)
                    isa_pkg::op_addi_w: d.alu_op = isa_pkg::alu_add;
                    isa_pkg::op_slti:   d.alu_op = isa_pkg::alu_slt;
                    isa_pkg::op_sltui:  d.alu_op = isa_pkg::alu_sltu;
                    isa_pkg::op_andi: begin
                        d.alu_op = isa_pkg::alu_and;
                        d.imm    = {20'h0, ins.ri12.imm12};
                    end
                    isa_pkg::op_ori: begin
                        d.alu_op = isa_pkg::alu_or;
                        d.imm    = {20'h0, ins.ri12.imm12};
                    end
                    isa_pkg::op_xori: begin
                        d.alu_op = isa_pkg::alu_xor;
                        d.imm    = {20'h0, ins.ri12.imm12};
                    end
                    default: begin
                        // lu12i.w adds the shifted immediate to r0
                        d.rj   = '0;
                        d.imm  = {ins.ri20.imm20, 12'h000};
                        known  = (ins.ri20.opcode7 == isa_pkg::op_lu12i_w);
                    end
                endcase
            end
        endcase
        d.we = known && (d.rd != '0);
        return d;
    endfunction

    logic                                     held_q;
    isa_pkg::instr_u                          held_instr_q;
    isa_pkg::word_t                           held_pc_q;
    logic [pipe_pkg::lanes-1:0]               slot_valid;
    isa_pkg::instr_u [pipe_pkg::lanes-1:0]    slot_instr;
    isa_pkg::word_t [pipe_pkg::lanes-1:0]     slot_pc;
    dec_t [pipe_pkg::lanes-1:0]               dec;
    isa_pkg::word_t [pipe_pkg::rd_ports-1:0]  opnd;
    pipe_pkg::issue_t [pipe_pkg::lanes-1:0]   issue_d;
    logic                                     dep;

    assign stall_o = held_q;

    // While a word is held, the source pair is ignored and slot 0 stays empty
    assign slot_valid    = held_q ? 2'b10 : instr_valid_i;
    assign slot_instr[0] = instr_i[0];
    assign slot_instr[1] = held_q ? held_instr_q : instr_i[1];
    assign slot_pc[0]    = pc_i;
    assign slot_pc[1]    = held_q ? held_pc_q : pc_i + 32'd4;

    always_comb begin
        for (int s = 0; s < pipe_pkg::lanes; s++) begin
            dec[s]            = decode(slot_instr[s]);
            rf_raddr_o[2*s]   = dec[s].rj;
            rf_raddr_o[2*s+1] = dec[s].rk;
        end
    end

    // Later matches override earlier ones, so the youngest producer wins
    always_comb begin
        for (int p = 0; p < pipe_pkg::rd_ports; p++) begin
            opnd[p] = rf_rdata_i[p];
            for (int l = 0; l < pipe_pkg::lanes; l++) begin
                if (commit_fwd_i[l].valid && commit_fwd_i[l].we &&
                    commit_fwd_i[l].rd == rf_raddr_o[p]) begin
                    opnd[p] = commit_fwd_i[l].value;
                end
            end
            for (int l = 0; l < pipe_pkg::lanes; l++) begin
                if (lane_issue_o[l].valid && lane_issue_o[l].we &&
                    lane_issue_o[l].rd == rf_raddr_o[p]) begin
                    opnd[p] = lane_fwd_value_i[l];
                end
            end
            if (rf_raddr_o[p] == '0) begin
                opnd[p] = '0;
            end
        end
    end

    // Slot 1 reads what slot 0 writes in the same pair
    assign dep = slot_valid[0] && slot_valid[1] && dec[0].we &&
                 (dec[1].rj == dec[0].rd || dec[1].rk == dec[0].rd);

    always_comb begin
        for (int l = 0; l < pipe_pkg::lanes; l++) begin
            issue_d[l].valid  = slot_valid[l];
            issue_d[l].pc     = slot_pc[l];
            issue_d[l].alu_op = dec[l].alu_op;
            issue_d[l].a      = opnd[2*l];
            issue_d[l].b      = dec[l].use_imm ? dec[l].imm : opnd[2*l+1];
            issue_d[l].rd     = dec[l].rd;
            issue_d[l].we     = dec[l].we;
        end
        if (dep) begin
            issue_d[1].valid = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            held_q       <= 1'b0;
            lane_issue_o <= '0;
        end else begin
            held_q       <= dep;
            lane_issue_o <= issue_d;
        end
    end

    always_ff @(posedge clk) begin
        if (dep) begin
            held_instr_q <= slot_instr[1];
            held_pc_q    <= slot_pc[1];
        end
    end

endmodule

// File: design/pipe_pkg.sv
package pipe_pkg;

    localparam int lanes    = 2;
    // Two source registers per lane
    localparam int rd_ports = 2 * lanes;

    // Operation leaving the issue register
    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     pc;
        isa_pkg::alu_op_e   alu_op;
        isa_pkg::word_t     a;
        isa_pkg::word_t     b;
        isa_pkg::reg_addr_t rd;
        logic               we;
    } issue_t;

    // Finished value held in a lane result register
    typedef struct packed {
        logic               valid;
        isa_pkg::word_t     pc;
        isa_pkg::reg_addr_t rd;
        logic               we;
        isa_pkg::word_t     value;
    } result_t;

endpackage

// File: design/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                                        clk,
    input  logic                                        reset_i,
    input  logic [pipe_pkg::lanes-1:0]                  we_i,
    input  isa_pkg::reg_addr_t [pipe_pkg::lanes-1:0]    waddr_i,
    input  isa_pkg::word_t [pipe_pkg::lanes-1:0]        wdata_i,
    input  isa_pkg::reg_addr_t [pipe_pkg::rd_ports-1:0] raddr_i,
    output isa_pkg::word_t [pipe_pkg::rd_ports-1:0]     rdata_o
);

    isa_pkg::word_t regs [32];

    // Port 1 is written last, so it wins on an address clash
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < pipe_pkg::lanes; w++) begin
                if (we_i[w] && waddr_i[w] != '0) begin
                    regs[waddr_i[w]] <= wdata_i[w];
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < pipe_pkg::rd_ports; p++) begin
            rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs[raddr_i[p]];
        end
    end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the core_backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert \
    -f core_backend.f \
    --top-module core_backend_tb \
    -Mdir obj_dir -o core_backend_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/core_backend_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" "$log"; then
    echo "Simulation reported failures"
    exit 1
fi

exit 0

// File: test/core_backend_assert.sv
`timescale 1ns/10ps

module core_backend_assert (
    input logic               clk,
    input logic               reset_i,
    input logic               stall_i,
    input logic [3:0]         wen0_i,
    input isa_pkg::reg_addr_t wnum0_i,
    input logic [3:0]         wen1_i,
    input isa_pkg::reg_addr_t wnum1_i
);

    // A pair split holds the source for one cycle only
    stall_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        stall_i |=> !stall_i)
        else $error("stall_o high in two consecutive cycles");

    wen_upper_zero: assert property (@(posedge clk) disable iff (reset_i)
        wen0_i[3:1] == 3'b000 && wen1_i[3:1] == 3'b000)
        else $error("upper debug wen bits are not zero");

    // r0 writes are never reported
    wnum0_nonzero: assert property (@(posedge clk) disable iff (reset_i)
        wen0_i[0] |-> wnum0_i != '0)
        else $error("debug0 reports a write to r0");

    wnum1_nonzero: assert property (@(posedge clk) disable iff (reset_i)
        wen1_i[0] |-> wnum1_i != '0)
        else $error("debug1 reports a write to r0");

endmodule

bind core_backend core_backend_assert u_assert (
    .clk     (clk),
    .reset_i (reset_i),
    .stall_i (stall_o),
    .wen0_i  (debug0_wb_rf_wen_o),
    .wnum0_i (debug0_wb_rf_wnum_o),
    .wen1_i  (debug1_wb_rf_wen_o),
    .wnum1_i (debug1_wb_rf_wnum_o)
);

// File: test/core_backend_tb.sv
`timescale 1ns/10ps

module core_backend_tb;

    localparam int num_pairs   = 400;
    localparam int cycle_limit = num_pairs * 2 + 50;

    localparam logic [16:0] r3_ops [8] = '{isa_pkg::op_add_w, isa_pkg::op_sub_w,
        isa_pkg::op_slt, isa_pkg::op_sltu, isa_pkg::op_and, isa_pkg::op_or,
        isa_pkg::op_xor, isa_pkg::op_nor};
    localparam logic [9:0] ri12_ops [6] = '{isa_pkg::op_addi_w, isa_pkg::op_slti,
        isa_pkg::op_sltui, isa_pkg::op_andi, isa_pkg::op_ori, isa_pkg::op_xori};

    // One expected register write
    typedef struct packed {
        isa_pkg::word_t     pc;
        isa_pkg::reg_addr_t rd;
        isa_pkg::word_t     value;
    } write_t;

    logic                  clk = 1'b0;
    logic                  reset_i;
    logic [1:0]            instr_valid_i;
    isa_pkg::instr_u [1:0] instr_i;
    isa_pkg::word_t        pc_i;
    logic                  stall_o;
    isa_pkg::word_t        debug0_wb_pc_o;
    logic [3:0]            debug0_wb_rf_wen_o;
    isa_pkg::reg_addr_t    debug0_wb_rf_wnum_o;
    isa_pkg::word_t        debug0_wb_rf_wdata_o;
    isa_pkg::word_t        debug1_wb_pc_o;
    logic [3:0]            debug1_wb_rf_wen_o;
    isa_pkg::reg_addr_t    debug1_wb_rf_wnum_o;
    isa_pkg::word_t        debug1_wb_rf_wdata_o;
    integer                seed;
    int                    cycles = 0;
    int                    value_errors = 0;
    int                    other_errors = 0;
    isa_pkg::word_t        model_regs [32];
    write_t                exp_q [$];

    core_backend uut (.*);

    always #4 clk = ~clk;

    // 0 unknown, 1 three registers, 2 register and imm12, 3 lu12i.w
    function automatic int word_format(isa_pkg::instr_u w);
        for (int i = 0; i < 8; i++) begin
            if (w.r3.opcode17 == r3_ops[i]) begin
                return 1;
            end
        end
        for (int i = 0; i < 6; i++) begin
            if (w.ri12.opcode10 == ri12_ops[i]) begin
                return 2;
            end
        end
        return (w.ri20.opcode7 == isa_pkg::op_lu12i_w) ? 3 : 0;
    endfunction

    // Slot 1 reads the register that slot 0 of the same pair writes
    function automatic logic pair_splits(logic [1:0] v, isa_pkg::instr_u [1:0] w);
        int f1;
        f1 = word_format(w[1]);
        if (v != 2'b11 || word_format(w[0]) == 0 || w[0].r3.rd == '0) begin
            return 1'b0;
        end
        return ((f1 == 1 || f1 == 2) && w[1].r3.rj == w[0].r3.rd) ||
               (f1 == 1 && w[1].r3.rk == w[0].r3.rd);
    endfunction

    // Register numbers stay within r0..r7 so words often depend on each other
    task automatic draw_word(output isa_pkg::instr_u w, output logic valid);
        logic [31:0] r;
        logic [31:0] f;
        logic [3:0]  kind;
        r       = $random(seed);
        f       = $random(seed);
        kind    = f[12:9];
        w       = {6'h3f, r[25:0]};
        w.r3.rd = {2'b00, f[2:0]};
        if (kind < 4'd14) begin
            w.r3.rj = {2'b00, f[5:3]};
        end
        if (kind < 4'd8) begin
            w.r3.rk       = {2'b00, f[8:6]};
            w.r3.opcode17 = r3_ops[kind[2:0]];
        end else if (kind < 4'd14) begin
            w.ri12.opcode10 = ri12_ops[3'(kind - 4'd8)];
        end else if (kind == 4'd14) begin
            w.ri20.opcode7 = isa_pkg::op_lu12i_w;
        end
        valid = (f[15:13] != 3'b000);
    endtask

    // Sequential execution of one accepted word
    task automatic execute_word(isa_pkg::instr_u w, isa_pkg::word_t pc);
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        isa_pkg::word_t v;
        a = model_regs[w.r3.rj];
        b = model_regs[w.r3.rk];
        v = '0;
        if (word_format(w) == 2) begin
            b = {{20{w.ri12.imm12[11]}}, w.ri12.imm12};
            if (w.ri12.opcode10 inside {isa_pkg::op_andi, isa_pkg::op_ori, isa_pkg::op_xori}) begin
                b[31:12] = '0;
            end
        end
        case (word_format(w))
            1: begin
                case (w.r3.opcode17)
                    isa_pkg::op_add_w: v = a + b;
                    isa_pkg::op_sub_w: v = a - b;
                    isa_pkg::op_slt:   v = {31'h0, $signed(a) < $signed(b)};
                    isa_pkg::op_sltu:  v = {31'h0, a < b};
                    isa_pkg::op_and:   v = a & b;
                    isa_pkg::op_or:    v = a | b;
                    isa_pkg::op_xor:   v = a ^ b;
                    default:           v = ~(a | b);
                endcase
            end
            2: begin
                case (w.ri12.opcode10)
                    isa_pkg::op_addi_w: v = a + b;
                    isa_pkg::op_slti:   v = {31'h0, $signed(a) < $signed(b)};
                    isa_pkg::op_sltui:  v = {31'h0, a < b};
                    isa_pkg::op_andi:   v = a & b;
                    isa_pkg::op_ori:    v = a | b;
                    default:            v = a ^ b;
                endcase
            end
            3: v = {w.ri20.imm20, 12'h000};
            default: return;
        endcase
        if (w.r3.rd != '0) begin
            model_regs[w.r3.rd] = v;
            exp_q.push_back(write_t'{pc: pc, rd: w.r3.rd, value: v});
        end
    endtask

    task automatic check_write_port(string name, logic [3:0] wen, write_t act);
        write_t exp;
        if (wen[0] !== 1'b1) begin
            return;
        end
        if (exp_q.size() == 0) begin
            other_errors++;
            $display("%s reported a write to r%0d that no accepted word makes", name, act.rd);
        end else begin
            exp = exp_q.pop_front();
            if (act !== exp) begin
                value_errors++;
                $display("ERROR %s write: expected pc %h rd %0d value %h, actual pc %h rd %0d value %h",
                         name, exp.pc, exp.rd, exp.value, act.pc, act.rd, act.value);
            end
        end
    endtask

    // Debug outputs change after the rising edge and are read mid-cycle
    always @(negedge clk) begin
        if (!reset_i) begin
            check_write_port("debug0", debug0_wb_rf_wen_o,
                             {debug0_wb_pc_o, debug0_wb_rf_wnum_o, debug0_wb_rf_wdata_o});
            check_write_port("debug1", debug1_wb_rf_wen_o,
                             {debug1_wb_pc_o, debug1_wb_rf_wnum_o, debug1_wb_rf_wdata_o});
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        isa_pkg::instr_u [1:0] w;
        logic [1:0]            v;
        isa_pkg::word_t        pc;
        logic                  split_exp;
        seed          = 32'h794f;
        pc            = 32'h1c00_0000;
        split_exp     = 1'b0;
        reset_i       <= 1'b1;
        instr_valid_i <= '0;
        instr_i       <= '0;
        pc_i          <= '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (4) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        if (stall_o !== 1'b0) begin
            other_errors++;
            $display("stall_o is not low after reset");
        end
        @(posedge clk);
        for (int n = 0; n < num_pairs; n++) begin
            draw_word(w[0], v[0]);
            draw_word(w[1], v[1]);
            instr_valid_i <= v;
            instr_i       <= w;
            pc_i          <= pc;
            @(posedge clk);
            // A split of the previous pair shows up as one stall cycle here
            if (stall_o !== split_exp) begin
                value_errors++;
                $display("ERROR split stall: expected %b, actual %b", split_exp, stall_o);
            end
            if (stall_o === 1'b1) begin
                @(posedge clk);
                if (stall_o !== 1'b0) begin
                    other_errors++;
                    $display("stall_o stayed high for a second cycle");
                end
            end
            split_exp = pair_splits(v, w);
            for (int s = 0; s < 2; s++) begin
                if (v[s]) begin
                    execute_word(w[s], pc + 4 * s);
                end
            end
            pc = pc + 32'd8;
        end
        instr_valid_i <= '0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
